//--- build.f
hw/core_pkg.sv
hw/mem_pkg.sv
hw/pc_gen.sv
hw/if_stage.sv
hw/sram_arbiter.sv
hw/sram_bank.sv
hw/fetch_top.sv
tb/fetch_tb.sv

//--- hw/core_pkg.sv
// core pipeline types
package core_pkg;

  localparam int PC_WD   = 64;
  localparam int INST_WD = 32;

  typedef logic [PC_WD-1:0] pc_t;

  localparam pc_t PC_RESET = 64'h0000_0000_8000_0000; // first fetch address

  // branch bus from decode/execute back to fetch
  typedef struct packed {
    logic br_stall;  // load-to-branch hazard, hold off fetch
    logic br_taken;
    pc_t  br_target;
  } br_bus_t;

  // fetch to decode payload
  typedef struct packed {
    logic [INST_WD-1:0] inst;
    pc_t                pc;
  } fs_to_ds_t;

endpackage

//--- hw/fetch_top.sv
// fetch front end top
`timescale 1ns/1ps

module fetch_top
  import core_pkg::*;
  import mem_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  // decode side
  input  logic      i_ds_allowin,
  input  br_bus_t   i_br,
  output logic      o_fs_to_ds_valid,
  output fs_to_ds_t o_fs_to_ds,
  // memory stage data port
  input  sram_req_t i_data_req,
  output sram_rsp_t o_data_rsp
);

  sram_req_t inst_req;
  sram_rsp_t inst_rsp;
  sram_req_t bank_req;
  sram_rsp_t bank_rsp;

  if_stage u_if_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_allowin     (i_ds_allowin),
    .i_br             (i_br),
    .o_fs_to_ds_valid (o_fs_to_ds_valid),
    .o_fs_to_ds       (o_fs_to_ds),
    .o_inst_req       (inst_req),
    .i_inst_rsp       (inst_rsp)
  );

  sram_arbiter u_sram_arbiter (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_inst_req (inst_req),
    .o_inst_rsp (inst_rsp),
    .i_data_req (i_data_req),
    .o_data_rsp (o_data_rsp),
    .o_bank_req (bank_req),
    .i_bank_rsp (bank_rsp)
  );

  sram_bank u_sram_bank (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_req   (bank_req),
    .o_rsp   (bank_rsp)
  );

endmodule

//--- hw/if_stage.sv
// instruction fetch stage
`timescale 1ns/1ps

module if_stage
  import core_pkg::*;
  import mem_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  // decode handshake
  input  logic      i_ds_allowin,
  input  br_bus_t   i_br,
  output logic      o_fs_to_ds_valid,
  output fs_to_ds_t o_fs_to_ds,
  // instruction sram port
  output sram_req_t o_inst_req,
  input  sram_rsp_t i_inst_rsp
);

  logic               fetch_en;   // low in the cycle right after reset
  logic               req_fire;
  logic               rsp_fire;
  logic               fs_valid;
  logic               fs_ready_go;
  logic               fs_allowin;
  pc_t                next_pc;
  pc_t                fs_pc;
  mem_word_u          rsp_word;
  logic [INST_WD-1:0] fetched_inst;
  logic               buf_valid;
  logic [INST_WD-1:0] buf_inst;

  assign req_fire = o_inst_req.req && i_inst_rsp.addr_ok;
  assign rsp_fire = i_inst_rsp.data_ok; // always taken by this master

  // stage has its instruction once data is back or parked in the buffer
  assign fs_ready_go      = rsp_fire || buf_valid;
  assign fs_allowin       = !fs_valid || (fs_ready_go && i_ds_allowin);
  assign o_fs_to_ds_valid = fs_valid && fs_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fetch_en <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
    end
  end

  // read request, 4 bytes at the next pc
  assign o_inst_req.req   = fetch_en && fs_allowin && !i_br.br_stall;
  assign o_inst_req.op    = 1'b0;
  assign o_inst_req.size  = SIZE_4B;
  assign o_inst_req.addr  = next_pc;
  assign o_inst_req.wstrb = '0;
  assign o_inst_req.wdata = '0;

  pc_gen u_pc_gen (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_load  (req_fire),
    .i_br    (i_br),
    .o_pc    (next_pc)
  );

  // one fetch in flight, valid from acceptance until handed to decode
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= req_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_fire) begin
      fs_pc <= next_pc; // pc of the request just taken
    end
  end

  // pick the 32-bit half of the returned word
  assign rsp_word.word = i_inst_rsp.rdata;
  assign fetched_inst  = fs_pc[2] ? rsp_word.half.hi : rsp_word.half.lo;

  // save buffer holds data that decode could not take
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      buf_valid <= 1'b0;
    end else if (i_ds_allowin) begin
      buf_valid <= 1'b0;
    end else if (rsp_fire) begin
      buf_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rsp_fire && !i_ds_allowin) begin
      buf_inst <= fetched_inst;
    end
  end

  assign o_fs_to_ds.inst = buf_valid ? buf_inst : fetched_inst;
  assign o_fs_to_ds.pc   = fs_pc;

  // no request may be outstanding while the buffer is occupied
  a_no_rsp_on_full_buf: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_inst_rsp.data_ok |-> !buf_valid
  ) else $error("if_stage: data_ok with save buffer full");

endmodule

//--- hw/mem_pkg.sv
// sram bus types
package mem_pkg;

  localparam int SRAM_ADDR_WD  = 64;
  localparam int SRAM_DATA_WD  = 64;
  localparam int SRAM_WSTRB_WD = SRAM_DATA_WD / 8;

  // bank geometry
  localparam int BANK_WORDS  = 512;
  localparam int BANK_IDX_WD = $clog2(BANK_WORDS);

  // transfer size codes, bytes = 1 << size
  localparam logic [1:0] SIZE_4B = 2'd2;
  localparam logic [1:0] SIZE_8B = 2'd3;

  // master to slave
  typedef struct packed {
    logic                     req;
    logic                     op;    // 1 write, 0 read
    logic [1:0]               size;
    logic [SRAM_ADDR_WD-1:0]  addr;
    logic [SRAM_WSTRB_WD-1:0] wstrb;
    logic [SRAM_DATA_WD-1:0]  wdata;
  } sram_req_t;

  // slave to master
  typedef struct packed {
    logic                    addr_ok; // request taken this cycle
    logic                    data_ok; // read data back or write done
    logic [SRAM_DATA_WD-1:0] rdata;
  } sram_rsp_t;

  // one memory word, as two instruction halves or as bytes
  typedef union packed {
    logic [SRAM_DATA_WD-1:0] word;
    struct packed {
      logic [SRAM_DATA_WD/2-1:0] hi; // address bit 2 set
      logic [SRAM_DATA_WD/2-1:0] lo;
    } half;
    logic [SRAM_WSTRB_WD-1:0][7:0] bytes;
  } mem_word_u;

endpackage

//--- hw/pc_gen.sv
// pre-fetch pc generator
`timescale 1ns/1ps

module pc_gen
  import core_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset,
  input  logic    i_load,  // fetch request accepted this cycle
  input  br_bus_t i_br,
  output pc_t     o_pc
);

  pc_t pc_q;
  pc_t pc_next;

  // redirect wins over the sequential step
  always_comb begin
    if (i_br.br_taken) begin
      pc_next = i_br.br_target;
    end else begin
      pc_next = pc_q + pc_t'(4);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q <= PC_RESET;
    end else if (i_load) begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

  // branch targets come from outside the fetch stage
  a_pc_aligned: assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_pc[1:0] == 2'b00
  ) else $error("pc_gen: misaligned fetch pc %h", o_pc);

endmodule

//--- hw/sram_arbiter.sv
// two-master sram arbiter
`timescale 1ns/1ps

module sram_arbiter
  import mem_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  // fetch master
  input  sram_req_t i_inst_req,
  output sram_rsp_t o_inst_rsp,
  // data master, higher priority
  input  sram_req_t i_data_req,
  output sram_rsp_t o_data_rsp,
  // to bank
  output sram_req_t o_bank_req,
  input  sram_rsp_t i_bank_rsp
);

  logic grant_data;
  logic grant_inst;
  logic bank_fire;
  logic owner_data_q; // owner of the request awaiting data_ok

  // fixed priority, fetch gets whatever the data port leaves
  assign grant_data = i_data_req.req;
  assign grant_inst = !i_data_req.req;

  assign o_bank_req = grant_data ? i_data_req : i_inst_req;
  assign bank_fire  = o_bank_req.req && i_bank_rsp.addr_ok;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      owner_data_q <= 1'b0;
    end else if (bank_fire) begin
      owner_data_q <= grant_data;
    end
  end

  // address phase goes to the granted master only
  assign o_inst_rsp.addr_ok = i_bank_rsp.addr_ok && grant_inst;
  assign o_data_rsp.addr_ok = i_bank_rsp.addr_ok && grant_data;

  // response phase steered by the recorded owner
  assign o_inst_rsp.data_ok = i_bank_rsp.data_ok && !owner_data_q;
  assign o_data_rsp.data_ok = i_bank_rsp.data_ok && owner_data_q;
  assign o_inst_rsp.rdata   = owner_data_q ? '0 : i_bank_rsp.rdata;
  assign o_data_rsp.rdata   = owner_data_q ? i_bank_rsp.rdata : '0;

  a_addr_ok_onehot: assert property (
    @(posedge i_clk) disable iff (i_reset)
    !(o_inst_rsp.addr_ok && o_data_rsp.addr_ok)
  ) else $error("sram_arbiter: addr_ok to both masters");

  // owner register only covers a single-cycle response
  a_rsp_next_cycle: assert property (
    @(posedge i_clk) disable iff (i_reset)
    bank_fire |=> i_bank_rsp.data_ok
  ) else $error("sram_arbiter: bank response not one cycle after accept");

endmodule

//--- hw/sram_bank.sv
// single-port 64-bit sram bank
`timescale 1ns/1ps

module sram_bank
  import mem_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  sram_req_t i_req,
  output sram_rsp_t o_rsp
);

  logic [SRAM_DATA_WD-1:0] mem [BANK_WORDS];
  logic [BANK_IDX_WD-1:0]  idx;
  logic                    fire;
  logic                    data_ok_q;
  logic [SRAM_DATA_WD-1:0] rdata_q;
  mem_word_u               old_word;
  mem_word_u               new_word;
  mem_word_u               merged_word;

  assign idx  = i_req.addr[BANK_IDX_WD+2:3]; // 8-byte word index
  assign fire = i_req.req;                   // addr_ok tied high

  // byte merge of write data into the stored word
  always_comb begin
    old_word.word = mem[idx];
    new_word.word = i_req.wdata;
    for (int b = 0; b < SRAM_WSTRB_WD; b++) begin
      merged_word.bytes[b] = i_req.wstrb[b] ? new_word.bytes[b] : old_word.bytes[b];
    end
  end

  always_ff @(posedge i_clk) begin
    if (fire && i_req.op) begin
      mem[idx] <= merged_word.word;
    end
    if (fire && !i_req.op) begin
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      data_ok_q <= 1'b0;
    end else begin
      data_ok_q <= fire;
    end
  end

  assign o_rsp.addr_ok = 1'b1;
  assign o_rsp.data_ok = data_ok_q;
  assign o_rsp.rdata   = rdata_q;

  // masters only issue naturally aligned 4- or 8-byte accesses
  a_size_align: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_req.req |-> (i_req.size == SIZE_8B && i_req.addr[2:0] == 3'b000)
               || (i_req.size == SIZE_4B && i_req.addr[1:0] == 2'b00)
  ) else $error("sram_bank: bad size or alignment at %h", i_req.addr);

endmodule

//--- tb/fetch_cases.txt
# op name addr data strb exp (hex); expect: addr=first pc or 0, data=count, strb=1 run 2 random
# expect exp=1 keeps decode running; stall: data=cycles, strb=level, exp=max deliveries held
write img_w0 80000000 0020011300100093 ff 0
write img_w1 80000008 0040021300300193 ff 0
write img_w2 80000010 0060031300500293 ff 0
write img_w3 80000018 0080041300700393 ff 0
write img_w4 80000020 00a0051300900493 ff 0
write img_w5 80000028 00c0061300b00593 ff 0
write img_w6 80000030 00e0071300d00693 ff 0
write img_w7 80000038 0100081300f00793 ff 0
stall release 0 0 0 0
expect seq_start 80000000 4 1 0
expect rand_stall 80000010 6 2 0
branch br_back 80000000 0 0 0
expect br_after 8000002c 4 1 0
stall hold 0 c 1 1
stall resume 0 0 0 0
expect stall_after 80000010 3 1 0
write strb_init 80000800 1122334455667788 ff 0
write strb_5a 80000800 a1b2c3d4e5f60718 5a 0
read strb_5a_rd 80000800 0 0 11b233d4e5660788
write strb_81 80000800 0123456789abcdef 81 0
read strb_81_rd 80000800 0 0 01b233d4e56607ef
expect mix_start 8000001c 2 1 1
read mix_rd0 80000000 0 0 0020011300100093
read mix_rd1 80000018 0 0 0080041300700393
expect mix_end 0 3 1 0

//--- tb/fetch_tb.sv
// fetch front end testbench
`timescale 1ns/1ps

module fetch_tb
  import core_pkg::*;
  import mem_pkg::*;
();

  localparam int CLK_HALF  = 20;
  localparam int MAX_CASES = 64;

  logic      clk;
  logic      reset;
  logic      ds_allowin;
  br_bus_t   br;
  logic      fs_valid;
  fs_to_ds_t fs_to_ds;
  sram_req_t data_req;
  sram_rsp_t data_rsp;

  string       c_op   [MAX_CASES];
  string       c_name [MAX_CASES];
  logic [63:0] c_addr [MAX_CASES];
  logic [63:0] c_data [MAX_CASES];
  logic [7:0]  c_strb [MAX_CASES];
  logic [63:0] c_exp  [MAX_CASES];
  int          n_cases;
  logic        cases_loaded;

  logic [SRAM_DATA_WD-1:0] shadow [BANK_WORDS]; // reference memory image
  fs_to_ds_t               seen [$];             // delivered pairs in order
  string                   cur_name;
  pc_t                     exp_pc;
  logic                    br_armed;
  pc_t                     br_target_exp;
  int                      br_seq_left;
  int                      seed;
  int                      err_fetch, err_rdata, err_count, err_other;

  fetch_top UUT (
    .i_clk            (clk),
    .i_reset          (reset),
    .i_ds_allowin     (ds_allowin),
    .i_br             (br),
    .o_fs_to_ds_valid (fs_valid),
    .o_fs_to_ds       (fs_to_ds),
    .i_data_req       (data_req),
    .o_data_rsp       (data_rsp)
  );

  always #CLK_HALF clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // instruction half picked by pc bit 2
  function automatic logic [INST_WD-1:0] inst_at(input pc_t pc);
    logic [SRAM_DATA_WD-1:0] word;
    word = shadow[pc[11:3]];
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  task automatic check_fetch(input string name, input fs_to_ds_t want, input fs_to_ds_t got);
    if (got !== want) begin
      err_fetch++;
      $display("FAIL %s: expected pc %h inst %h, actual pc %h inst %h",
               name, want.pc, want.inst, got.pc, got.inst);
    end
  endtask

  task automatic check_rdata(input string name, input logic [SRAM_DATA_WD-1:0] want,
                             input logic [SRAM_DATA_WD-1:0] got);
    if (got !== want) begin
      err_rdata++;
      $display("FAIL %s: expected rdata %h, actual %h", name, want, got);
    end
  endtask

  task automatic check_count(input string name, input int want, input int got);
    if (got > want) begin
      err_count++;
      $display("FAIL %s: expected at most %0d deliveries, actual %0d", name, want, got);
    end
  endtask

  // one 8-byte access on the data port
  task automatic data_access(input logic wr, input logic [63:0] addr, input logic [63:0] wdata,
                             input logic [7:0] wstrb, output logic [63:0] rdata);
    data_req.req   = 1'b1;
    data_req.op    = wr;
    data_req.size  = SIZE_8B;
    data_req.addr  = addr;
    data_req.wstrb = wr ? wstrb : '0;
    data_req.wdata = wdata;
    @(negedge clk);
    while (!data_rsp.addr_ok) @(negedge clk);
    next_cycle();             // accepted on that edge
    data_req = '0;
    @(negedge clk);
    while (!data_rsp.data_ok) @(negedge clk);
    rdata = data_rsp.rdata;
    next_cycle();
  endtask

  task automatic shadow_write(input logic [63:0] addr, input logic [63:0] wdata,
                              input logic [7:0] wstrb);
    for (int b = 0; b < 8; b++) begin
      if (wstrb[b]) shadow[addr[11:3]][8*b +: 8] = wdata[8*b +: 8];
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    r;
    int    c;
    string op;
    n_cases = 0;
    fd = $fopen("tb/fetch_cases.txt", "r");
    if (fd == 0) begin
      err_other++;
      $display("cannot open case file tb/fetch_cases.txt");
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op.substr(0, 0) == "#") begin
          c = $fgetc(fd); // skip rest of comment line
          while (c != 10 && c != -1) c = $fgetc(fd);
        end else begin
          r = $fscanf(fd, "%s %h %h %h %h", c_name[n_cases], c_addr[n_cases],
                      c_data[n_cases], c_strb[n_cases], c_exp[n_cases]);
          if (r != 5) begin
            err_other++;
            $display("case line %0d with operation %s has %0d of 5 fields", n_cases, op, r);
          end
          c_op[n_cases] = op;
          n_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(input int i);
    logic [63:0] rdata;
    int          start;
    int          stall_left;
    logic [31:0] rnd;
    fs_to_ds_t   want;
    cur_name = c_name[i];
    start    = seen.size();
    if (c_op[i] == "write") begin
      data_access(1'b1, c_addr[i], c_data[i], c_strb[i], rdata);
      shadow_write(c_addr[i], c_data[i], c_strb[i]);
    end else if (c_op[i] == "read") begin
      data_access(1'b0, c_addr[i], '0, '0, rdata);
      check_rdata(c_name[i], c_exp[i], rdata);
    end else if (c_op[i] == "branch") begin
      br_target_exp = c_addr[i];
      br_seq_left   = 2;
      br_armed      = 1'b1;
      br.br_taken   = 1'b1;
      br.br_target  = c_addr[i];
      ds_allowin    = 1'b1;
      while (seen.size() == start) next_cycle(); // held until the next delivery
      br.br_taken = 1'b0;
    end else if (c_op[i] == "stall") begin
      br.br_stall = c_strb[i][0];
      if (c_strb[i][0]) ds_allowin = 1'b1;
      repeat (c_data[i]) next_cycle();
      if (c_strb[i][0]) check_count(c_name[i], int'(c_exp[i]), seen.size() - start);
    end else if (c_op[i] == "expect") begin
      stall_left = 0;
      while (seen.size() < start + int'(c_data[i])) begin
        if (c_strb[i] == 8'd2 && stall_left > 0) begin
          ds_allowin = 1'b0;
          stall_left--;
        end else begin
          ds_allowin = 1'b1;
          if (c_strb[i] == 8'd2) begin
            rnd = $random(seed);
            if (rnd[0]) stall_left = rnd[3:1]; // next decode stall length
          end
        end
        next_cycle();
      end
      ds_allowin = c_exp[i][0];
      if (c_addr[i] != 0) begin
        want.pc   = c_addr[i];
        want.inst = inst_at(c_addr[i]);
        check_fetch(c_name[i], want, seen[start]);
      end
    end else begin
      err_other++;
      $display("case %s has unknown operation %s", c_name[i], c_op[i]);
    end
  endtask

  // checks every handoff to decode against the sequential pc model
  always @(negedge clk) begin : delivery_monitor
    fs_to_ds_t want;
    if (!reset && fs_valid && ds_allowin) begin
      if (br_armed && fs_to_ds.pc == br_target_exp) begin
        br_armed = 1'b0;
        exp_pc   = br_target_exp;
      end else if (br_armed) begin
        if (br_seq_left == 0) begin
          err_other++;
          br_armed = 1'b0;
          $display("%s: branch target %h not delivered within two instructions",
                   cur_name, br_target_exp);
        end else begin
          br_seq_left--;
        end
      end
      want.pc   = exp_pc;
      want.inst = inst_at(exp_pc);
      check_fetch(cur_name, want, fs_to_ds);
      exp_pc = exp_pc + pc_t'(4);
      seen.push_back(fs_to_ds);
    end
  end

  initial begin : watchdog
    wait (cases_loaded);
    repeat ((n_cases + 1) * 200) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", (n_cases + 1) * 200);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    ds_allowin   = 1'b0;
    br           = '0;
    br.br_stall  = 1'b1; // no fetch until the image is loaded
    data_req     = '0;
    seed         = 8366;
    exp_pc       = PC_RESET;
    br_armed     = 1'b0;
    cases_loaded = 1'b0;
    err_fetch    = 0;
    err_rdata    = 0;
    err_count    = 0;
    err_other    = 0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int i = 0; i < n_cases; i++) run_case(i);
    $display("errors: fetch %0d, rdata %0d, count %0d, other %0d (%0d cases, %0d deliveries)",
             err_fetch, err_rdata, err_count, err_other, n_cases, seen.size());
    if (err_fetch + err_rdata + err_count + err_other == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
